/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_spi_bridge
FLIST     = flist.f
BUILD     = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

/* flist.f */
source/bridge_pkg.sv
source/spi_link_if.sv
source/spi_sync.sv
source/addr_loader.sv
source/spi_channel.sv
source/gpo_reg.sv
source/miso_select.sv
source/heartbeat_gen.sv
source/spi_bridge_top.sv
sim/spi_bridge_sva.sv
sim/tb_spi_bridge.sv

/* sim/spi_bridge_sva.sv */
`timescale 1ns/100ps

module spi_bridge_sva (
	input logic clk,
	input logic rst,
	// Unit selects
	input logic addr_sel,
	input logic adc_sel,
	input logic dac_sel,
	input logic gpo0_sel,
	input logic gpo1_sel,
	// Device pins
	input logic cs_adc,
	input logic cs_dac,
	input logic ck_adc,
	input logic ck_dac
);

	// ************************************************************************
	// Bus ownership
	// ************************************************************************
	// One reply source at a time
	sel_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0({addr_sel, adc_sel, dac_sel, gpo0_sel, gpo1_sel}))
		else $error("more than one unit selected");

	// ADC and DAC never addressed together
	cs_exclusive: assert property (@(posedge clk) disable iff (rst)
		cs_adc || cs_dac)
		else $error("ADC and DAC chip selects low together");

	// Deselected channel keeps a quiet clock
	adc_ck_idle: assert property (@(posedge clk) disable iff (rst)
		cs_adc |-> !ck_adc)
		else $error("ADC clock active while deselected");

	dac_ck_idle: assert property (@(posedge clk) disable iff (rst)
		cs_dac |-> !ck_dac)
		else $error("DAC clock active while deselected");

endmodule

bind spi_bridge_top spi_bridge_sva u_sva (
	.clk(clk), .rst(rst),
	.addr_sel(addr_sel), .adc_sel(adc_sel), .dac_sel(dac_sel),
	.gpo0_sel(gpo0_sel), .gpo1_sel(gpo1_sel),
	.cs_adc(cs_adc), .cs_dac(cs_dac), .ck_adc(ck_adc), .ck_dac(ck_dac)
);

/* sim/tb_spi_bridge.sv */
`timescale 1ns/100ps

module tb_spi_bridge;

	// ************************************************************************
	// Timing and test lengths
	// ************************************************************************
	localparam int CLK_PERIOD   = 8;
	// clk cycles per half SPI bit
	localparam int HALF_BIT     = 8;
	// Wait after a pin change before checking
	localparam int SETTLE       = 4;
	localparam int N_ADDR       = 24;
	localparam int N_GPO        = 20;
	localparam int N_BURST      = 64;
	// Gap plus 8-bit frame plus settle, rounded up
	localparam int FRAME_CYCLES = 160;
	localparam int N_FRAMES     = N_ADDR + 2 * N_GPO + 4;
	localparam int WATCHDOG_NS  =
		(N_FRAMES * FRAME_CYCLES + 3 * N_BURST * SETTLE + 1000) * CLK_PERIOD;
	localparam logic [31:0] SEED = 32'hd887_a6ca;

	logic clk;
	logic rst;
	logic heartbeat;
	// Microcontroller side
	logic cs_addr_u, cs_u, ck_u, mo_u, o0_u, o1_u;
	logic mi_u, i0_u, i1_u;
	// Device sides
	logic cs_adc, ck_adc, mo_adc, o0_adc, o1_adc, mi_adc, i0_adc, i1_adc;
	logic cs_dac, ck_dac, mo_dac, o0_dac, o1_dac, mi_dac, i0_dac, i1_dac;
	bridge_pkg::gpo_word_t gpo_out;
	bridge_pkg::gpo_word_t gpo1_out;

	// Reference model
	bridge_pkg::dev_addr_t model_addr;
	bridge_pkg::gpo_word_t model_gpo0;
	bridge_pkg::gpo_word_t model_gpo1;
	logic [31:0]           lfsr;

	spi_bridge_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Hang guard
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog timeout: the test sequence did not finish in %0d ns", WATCHDOG_NS);
		abort_run();
	end

	// ************************************************************************
	// Helpers
	// ************************************************************************
	task automatic abort_run();
		$display("Simulation FAILED");
		$fatal(1, "run stopped");
	endtask

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] bits;
		int          i;
		bits = '0;
		for (i = 0; i < n; i++) begin
			bits = {bits[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return bits;
	endfunction

	// Three in four frames full length, rest 1 to 7 bits
	function automatic int pick_length();
		logic [31:0] r;
		r = next_bits(5);
		if (r[4:3] != 2'b00)
			return 8;
		return 1 + int'(r[2:0]) % 7;
	endfunction

	// Returns at 1 ns past a rising edge
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic compare_addr(input bridge_pkg::dev_addr_t got,
		input bridge_pkg::dev_addr_t exp, input string what);
		if (got !== exp) begin
			$display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic verify_gpo(input bridge_pkg::gpo_word_t got,
		input bridge_pkg::gpo_word_t exp, input string what);
		if (got !== exp) begin
			$display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic match_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("FAIL %0t ns: %s is %b, expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	// ************************************************************************
	// SPI frames
	// ************************************************************************
	// Mode 0, MSB first; mi_u sampled just before each ck rise
	task automatic spi_frame(input logic on_addr, input int nbits, input logic [7:0] tx,
		output logic [7:0] rx);
		int i;
		rx = '0;
		// Idle gap so readback copies reload
		wait_cycles(HALF_BIT);
		if (on_addr)
			cs_addr_u = 1'b0;
		else
			cs_u = 1'b0;
		for (i = nbits - 1; i >= 0; i--) begin
			mo_u = tx[i];
			wait_cycles(HALF_BIT);
			rx = {rx[6:0], mi_u};
			ck_u = 1'b1;
			wait_cycles(HALF_BIT);
			ck_u = 1'b0;
		end
		mo_u = 1'b0;
		wait_cycles(HALF_BIT);
		cs_addr_u = 1'b1;
		cs_u = 1'b1;
		wait_cycles(SETTLE);
	endtask

	// Readback holds the address from before the frame
	task automatic load_address(input bridge_pkg::dev_addr_t value, input int nbits);
		logic [7:0] rx;
		spi_frame(1'b1, nbits, value, rx);
		compare_addr(rx, bridge_pkg::dev_addr_t'(model_addr >> (8 - nbits)), "address readback");
		if (nbits == 8)
			model_addr = value;
	endtask

	task automatic write_gpo(input logic second, input bridge_pkg::gpo_word_t value,
		input int nbits);
		logic [7:0]            rx;
		bridge_pkg::gpo_word_t held;
		load_address(second ? bridge_pkg::ADDR_GPO1 : bridge_pkg::ADDR_GPO0, 8);
		held = second ? model_gpo1 : model_gpo0;
		spi_frame(1'b0, nbits, value, rx);
		verify_gpo(rx, bridge_pkg::gpo_word_t'(held >> (8 - nbits)), "gpo readback");
		// Short frames commit nothing
		if (nbits == 8 && second)
			model_gpo1 = value;
		else if (nbits == 8)
			model_gpo0 = value;
		verify_gpo(gpo_out, model_gpo0, "gpo_out");
		verify_gpo(gpo1_out, model_gpo1, "gpo1_out");
	endtask

	// ************************************************************************
	// Pass-through checks
	// ************************************************************************
	// Expected pins from current levels and the selected unit
	task automatic verify_ports();
		logic adc_on;
		logic dac_on;
		adc_on = (model_addr == bridge_pkg::ADDR_ADC) && !cs_u;
		dac_on = (model_addr == bridge_pkg::ADDR_DAC) && !cs_u;
		match_bit(cs_adc, !adc_on, "cs_adc");
		match_bit(ck_adc, adc_on & ck_u, "ck_adc");
		match_bit(mo_adc, adc_on & mo_u, "mo_adc");
		match_bit(o0_adc, adc_on & o0_u, "o0_adc");
		match_bit(o1_adc, adc_on & o1_u, "o1_adc");
		match_bit(cs_dac, !dac_on, "cs_dac");
		match_bit(ck_dac, dac_on & ck_u, "ck_dac");
		match_bit(mo_dac, dac_on & mo_u, "mo_dac");
		match_bit(o0_dac, dac_on & o0_u, "o0_dac");
		match_bit(o1_dac, dac_on & o1_u, "o1_dac");
		// Replies only from the owner, zero otherwise
		match_bit(mi_u, (adc_on & mi_adc) | (dac_on & mi_dac), "mi_u");
		match_bit(i0_u, (adc_on & i0_adc) | (dac_on & i0_dac), "i0_u");
		match_bit(i1_u, (adc_on & i1_adc) | (dac_on & i1_dac), "i1_u");
		match_bit(heartbeat, 1'b0, "heartbeat");
	endtask

	// Random levels on every microcontroller and device reply line
	task automatic pin_burst(input int steps);
		int          k;
		logic [31:0] r;
		for (k = 0; k < steps; k++) begin
			r = next_bits(5);
			{cs_u, ck_u, mo_u, o0_u, o1_u} = r[4:0];
			r = next_bits(6);
			{mi_adc, i0_adc, i1_adc, mi_dac, i0_dac, i1_dac} = r[5:0];
			wait_cycles(SETTLE);
			verify_ports();
		end
		cs_u = 1'b1;
		ck_u = 1'b0;
		mo_u = 1'b0;
		o0_u = 1'b0;
		o1_u = 1'b0;
		wait_cycles(HALF_BIT);
	endtask

	// ************************************************************************
	// Test sequence
	// ************************************************************************
	initial begin
		bridge_pkg::dev_addr_t rnd_addr;
		logic [31:0]           r;
		int                    k;
		lfsr = SEED;
		rst = 1'b1;
		cs_addr_u = 1'b1;
		cs_u = 1'b1;
		ck_u = 1'b0;
		mo_u = 1'b0;
		o0_u = 1'b0;
		o1_u = 1'b0;
		{mi_adc, i0_adc, i1_adc} = 3'b000;
		{mi_dac, i0_dac, i1_dac} = 3'b000;
		model_addr = bridge_pkg::ADDR_RESET;
		model_gpo0 = bridge_pkg::GPO0_RESET;
		model_gpo1 = bridge_pkg::GPO1_RESET;
		wait_cycles(4);
		rst = 1'b0;

		// Reset values at the ports
		wait_cycles(SETTLE);
		verify_ports();
		verify_gpo(gpo_out, model_gpo0, "gpo_out after reset");
		verify_gpo(gpo1_out, model_gpo1, "gpo1_out after reset");

		// Random addresses, some frames cut short
		for (k = 0; k < N_ADDR; k++) begin
			r = next_bits(8);
			load_address(r[7:0], pick_length());
		end

		// Each channel in turn, the other idle
		load_address(bridge_pkg::ADDR_ADC, 8);
		pin_burst(N_BURST);
		load_address(bridge_pkg::ADDR_DAC, 8);
		pin_burst(N_BURST);

		// Output register writes
		for (k = 0; k < N_GPO; k++) begin
			r = next_bits(9);
			write_gpo(r[8], r[7:0], pick_length());
		end

		// Address nobody owns
		do begin
			r = next_bits(8);
			rnd_addr = r[7:0];
		end while (rnd_addr == bridge_pkg::ADDR_ADC || rnd_addr == bridge_pkg::ADDR_DAC ||
			rnd_addr == bridge_pkg::ADDR_GPO0 || rnd_addr == bridge_pkg::ADDR_GPO1);
		load_address(rnd_addr, 8);
		pin_burst(N_BURST);

		// Last load read back here
		load_address(bridge_pkg::ADDR_RESET, 8);
		verify_gpo(gpo_out, model_gpo0, "gpo_out at end");
		verify_gpo(gpo1_out, model_gpo1, "gpo1_out at end");
		$display("Simulation PASSED");
		$finish;
	end

endmodule

/* source/addr_loader.sv */
`timescale 1ns/100ps

module addr_loader (
	input  logic                  clk,
	input  logic                  rst,
	spi_link_if.dst               link,
	output bridge_pkg::dev_addr_t addr,
	output logic                  mi,
	output logic                  sel
);

	// Bits seen in the current frame, saturates at ADDR_BITS
	logic [$clog2(bridge_pkg::ADDR_BITS + 1)-1:0] bit_cnt;
	// Incoming address bits
	bridge_pkg::dev_addr_t                        shift_q;
	// Copy of addr shifted out for readback
	bridge_pkg::dev_addr_t                        rd_q;

	// Frame active while address chip select is low
	assign sel = ~link.cs_addr;

	// ************************************************************************
	// Bit counter and input shift
	// ************************************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			bit_cnt <= '0;
		end else if (link.cs_addr) begin
			bit_cnt <= '0;
		end else if (link.ck_rise && bit_cnt != bridge_pkg::ADDR_BITS) begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// MSB first, last 8 bits win on long frames
	always_ff @(posedge clk) begin
		if (!link.cs_addr && link.ck_rise) begin
			shift_q <= {shift_q[bridge_pkg::ADDR_BITS-2:0], link.mo};
		end
	end

	// Commit at frame end, short frames are dropped
	always_ff @(posedge clk) begin
		if (rst) begin
			addr <= bridge_pkg::ADDR_RESET;
		end else if (link.cs_addr_rise && bit_cnt == bridge_pkg::ADDR_BITS) begin
			addr <= shift_q;
		end
	end

	// ************************************************************************
	// Readback
	// ************************************************************************
	// Reloaded while idle, so a frame returns the address held before it
	always_ff @(posedge clk) begin
		if (link.cs_addr) begin
			rd_q <= addr;
		end else if (link.ck_rise) begin
			rd_q <= {rd_q[bridge_pkg::ADDR_BITS-2:0], 1'b0};
		end
	end

	assign mi = rd_q[bridge_pkg::ADDR_BITS-1];

endmodule

/* source/bridge_pkg.sv */
package bridge_pkg;

	// ************************************************************************
	// Widths
	// ************************************************************************
	localparam int ADDR_BITS   = 8;
	localparam int GPO_BITS    = 8;
	// Top bit toggles every 2^26 cycles
	localparam int HB_BITS     = 27;
	// Flops between a microcontroller pin and the clk domain
	localparam int SYNC_STAGES = 2;

	// ************************************************************************
	// Types
	// ************************************************************************
	typedef logic [ADDR_BITS-1:0] dev_addr_t;
	typedef logic [GPO_BITS-1:0]  gpo_word_t;
	typedef logic [HB_BITS-1:0]   hb_count_t;

	// ************************************************************************
	// Address map
	// ************************************************************************
	localparam dev_addr_t ADDR_ADC  = 8'h08;
	localparam dev_addr_t ADDR_DAC  = 8'h04;
	localparam dev_addr_t ADDR_GPO0 = 8'h30;
	localparam dev_addr_t ADDR_GPO1 = 8'h31;

	// Reset values
	// No unit owns the loader reset address
	localparam dev_addr_t ADDR_RESET = 8'h00;
	localparam gpo_word_t GPO0_RESET = 8'h00;
	localparam gpo_word_t GPO1_RESET = 8'h04;

endpackage

/* source/gpo_reg.sv */
`timescale 1ns/100ps

module gpo_reg #(
	parameter bridge_pkg::dev_addr_t DEV_ADDR    = bridge_pkg::ADDR_GPO0,
	parameter bridge_pkg::gpo_word_t RESET_VALUE = bridge_pkg::GPO0_RESET
) (
	input  logic                  clk,
	input  logic                  rst,
	spi_link_if.dst               link,
	input  bridge_pkg::dev_addr_t addr,
	output bridge_pkg::gpo_word_t gpo_out,
	output logic                  sel,
	output logic                  mi
);

	// Bits seen in the current frame, saturates at GPO_BITS
	logic [$clog2(bridge_pkg::GPO_BITS + 1)-1:0] bit_cnt;
	// Incoming write data
	bridge_pkg::gpo_word_t                       shift_q;
	// Readback copy of the output register
	bridge_pkg::gpo_word_t                       rd_q;

	// Selected while addressed and cs is low
	assign sel = (addr == DEV_ADDR) && !link.cs;

	// ************************************************************************
	// Write path
	// ************************************************************************
	// Cleared between frames, only counts in selected frames
	always_ff @(posedge clk) begin
		if (rst) begin
			bit_cnt <= '0;
		end else if (link.cs) begin
			bit_cnt <= '0;
		end else if (sel && link.ck_rise && bit_cnt != bridge_pkg::GPO_BITS) begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// MSB first
	always_ff @(posedge clk) begin
		if (sel && link.ck_rise) begin
			shift_q <= {shift_q[bridge_pkg::GPO_BITS-2:0], link.mo};
		end
	end

	// Full count implies this unit was selected for the frame
	always_ff @(posedge clk) begin
		if (rst) begin
			gpo_out <= RESET_VALUE;
		end else if (link.cs_rise && bit_cnt == bridge_pkg::GPO_BITS) begin
			gpo_out <= shift_q;
		end
	end

	// ************************************************************************
	// Readback
	// ************************************************************************
	// Loaded while cs is high, holds the value from before the frame
	always_ff @(posedge clk) begin
		if (link.cs) begin
			rd_q <= gpo_out;
		end else if (sel && link.ck_rise) begin
			rd_q <= {rd_q[bridge_pkg::GPO_BITS-2:0], 1'b0};
		end
	end

	assign mi = rd_q[bridge_pkg::GPO_BITS-1];

endmodule

/* source/heartbeat_gen.sv */
`timescale 1ns/100ps

module heartbeat_gen (
	input  logic clk,
	input  logic rst,
	output logic heartbeat
);

	// Free-running prescaler
	bridge_pkg::hb_count_t count;

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	// Slow blink from the top bit
	assign heartbeat = count[bridge_pkg::HB_BITS-1];

endmodule

/* source/miso_select.sv */
`timescale 1ns/100ps

module miso_select (
	input  logic clk,
	input  logic rst,
	// Address loader
	input  logic addr_sel,
	input  logic addr_mi,
	// ADC channel
	input  logic adc_sel,
	input  logic adc_mi,
	input  logic adc_i0,
	input  logic adc_i1,
	// DAC channel
	input  logic dac_sel,
	input  logic dac_mi,
	input  logic dac_i0,
	input  logic dac_i1,
	// Output registers
	input  logic gpo0_sel,
	input  logic gpo0_mi,
	input  logic gpo1_sel,
	input  logic gpo1_mi,
	// Toward the microcontroller
	output logic mi_u,
	output logic i0_u,
	output logic i1_u
);

	logic mi_next;
	logic i0_next;
	logic i1_next;

	// One-hot AND-OR, no priority, zero when nothing is selected
	assign mi_next = (addr_sel & addr_mi) | (adc_sel & adc_mi) | (dac_sel & dac_mi) |
		(gpo0_sel & gpo0_mi) | (gpo1_sel & gpo1_mi);
	// Side lines exist on the channels only
	assign i0_next = (adc_sel & adc_i0) | (dac_sel & dac_i0);
	assign i1_next = (adc_sel & adc_i1) | (dac_sel & dac_i1);

	// One cycle behind the selected source
	always_ff @(posedge clk) begin
		if (rst) begin
			mi_u <= 1'b0;
			i0_u <= 1'b0;
			i1_u <= 1'b0;
		end else begin
			mi_u <= mi_next;
			i0_u <= i0_next;
			i1_u <= i1_next;
		end
	end

endmodule

/* source/spi_bridge_top.sv */
`timescale 1ns/100ps

module spi_bridge_top (
	input  logic                  clk,
	input  logic                  rst,
	output logic                  heartbeat,
	// Microcontroller SPI
	input  logic                  cs_addr_u,
	input  logic                  cs_u,
	input  logic                  ck_u,
	input  logic                  mo_u,
	output logic                  mi_u,
	input  logic                  o0_u,
	input  logic                  o1_u,
	output logic                  i0_u,
	output logic                  i1_u,
	// ADC
	output logic                  cs_adc,
	output logic                  ck_adc,
	output logic                  mo_adc,
	input  logic                  mi_adc,
	output logic                  o0_adc,
	output logic                  o1_adc,
	input  logic                  i0_adc,
	input  logic                  i1_adc,
	// DAC
	output logic                  cs_dac,
	output logic                  ck_dac,
	output logic                  mo_dac,
	input  logic                  mi_dac,
	output logic                  o0_dac,
	output logic                  o1_dac,
	input  logic                  i0_dac,
	input  logic                  i1_dac,
	// General-purpose outputs
	output bridge_pkg::gpo_word_t gpo_out,
	output bridge_pkg::gpo_word_t gpo1_out
);

	// Current device address, shared by all units
	bridge_pkg::dev_addr_t addr;

	// Per-unit select and reply lines
	logic addr_sel, addr_mi;
	logic adc_sel, adc_mi, adc_i0, adc_i1;
	logic dac_sel, dac_mi, dac_i0, dac_i1;
	logic gpo0_sel, gpo0_mi;
	logic gpo1_sel, gpo1_mi;

	spi_link_if link ();

	// ************************************************************************
	// Microcontroller side
	// ************************************************************************
	spi_sync u_sync (
		.clk(clk), .rst(rst),
		.cs_addr_u(cs_addr_u), .cs_u(cs_u), .ck_u(ck_u),
		.mo_u(mo_u), .o0_u(o0_u), .o1_u(o1_u),
		.link(link.src)
	);

	addr_loader u_addr (
		.clk(clk), .rst(rst), .link(link.dst),
		.addr(addr), .mi(addr_mi), .sel(addr_sel)
	);

	// ************************************************************************
	// SPI channels
	// ************************************************************************
	spi_channel #(.DEV_ADDR(bridge_pkg::ADDR_ADC)) u_adc (
		.clk(clk), .rst(rst), .link(link.dst), .addr(addr),
		.mi_dev(mi_adc), .i0_dev(i0_adc), .i1_dev(i1_adc),
		.cs_dev(cs_adc), .ck_dev(ck_adc), .mo_dev(mo_adc), .o0_dev(o0_adc), .o1_dev(o1_adc),
		.sel(adc_sel), .mi(adc_mi), .i0(adc_i0), .i1(adc_i1)
	);

	spi_channel #(.DEV_ADDR(bridge_pkg::ADDR_DAC)) u_dac (
		.clk(clk), .rst(rst), .link(link.dst), .addr(addr),
		.mi_dev(mi_dac), .i0_dev(i0_dac), .i1_dev(i1_dac),
		.cs_dev(cs_dac), .ck_dev(ck_dac), .mo_dev(mo_dac), .o0_dev(o0_dac), .o1_dev(o1_dac),
		.sel(dac_sel), .mi(dac_mi), .i0(dac_i0), .i1(dac_i1)
	);

	// ************************************************************************
	// Output registers
	// ************************************************************************
	gpo_reg #(.DEV_ADDR(bridge_pkg::ADDR_GPO0), .RESET_VALUE(bridge_pkg::GPO0_RESET)) u_gpo0 (
		.clk(clk), .rst(rst), .link(link.dst), .addr(addr),
		.gpo_out(gpo_out), .sel(gpo0_sel), .mi(gpo0_mi)
	);

	gpo_reg #(.DEV_ADDR(bridge_pkg::ADDR_GPO1), .RESET_VALUE(bridge_pkg::GPO1_RESET)) u_gpo1 (
		.clk(clk), .rst(rst), .link(link.dst), .addr(addr),
		.gpo_out(gpo1_out), .sel(gpo1_sel), .mi(gpo1_mi)
	);

	// Reply toward the microcontroller
	miso_select u_miso (
		.clk(clk), .rst(rst),
		.addr_sel(addr_sel), .addr_mi(addr_mi),
		.adc_sel(adc_sel), .adc_mi(adc_mi), .adc_i0(adc_i0), .adc_i1(adc_i1),
		.dac_sel(dac_sel), .dac_mi(dac_mi), .dac_i0(dac_i0), .dac_i1(dac_i1),
		.gpo0_sel(gpo0_sel), .gpo0_mi(gpo0_mi),
		.gpo1_sel(gpo1_sel), .gpo1_mi(gpo1_mi),
		.mi_u(mi_u), .i0_u(i0_u), .i1_u(i1_u)
	);

	heartbeat_gen u_hb (
		.clk(clk), .rst(rst), .heartbeat(heartbeat)
	);

endmodule

/* source/spi_channel.sv */
`timescale 1ns/100ps

module spi_channel #(
	parameter bridge_pkg::dev_addr_t DEV_ADDR = bridge_pkg::ADDR_ADC
) (
	input  logic                  clk,
	input  logic                  rst,
	spi_link_if.dst               link,
	input  bridge_pkg::dev_addr_t addr,
	// Reply lines from the device
	input  logic                  mi_dev,
	input  logic                  i0_dev,
	input  logic                  i1_dev,
	// Device pins
	output logic                  cs_dev,
	output logic                  ck_dev,
	output logic                  mo_dev,
	output logic                  o0_dev,
	output logic                  o1_dev,
	// Toward the reply multiplexer
	output logic                  sel,
	output logic                  mi,
	output logic                  i0,
	output logic                  i1
);

	// ************************************************************************
	// Address decode
	// ************************************************************************
	// Owns the bus only while addressed and cs is low
	assign sel = (addr == DEV_ADDR) && !link.cs;

	// ************************************************************************
	// Device pin register
	// ************************************************************************
	// One flop past the synchronizer, 3 cycles from the pin
	always_ff @(posedge clk) begin
		if (rst) begin
			cs_dev <= 1'b1;
			ck_dev <= 1'b0;
			mo_dev <= 1'b0;
			o0_dev <= 1'b0;
			o1_dev <= 1'b0;
		end else if (sel) begin
			cs_dev <= link.cs;
			ck_dev <= link.ck;
			mo_dev <= link.mo;
			o0_dev <= link.o0;
			o1_dev <= link.o1;
		end else begin
			// Idle device, deselected with quiet lines
			cs_dev <= 1'b1;
			ck_dev <= 1'b0;
			mo_dev <= 1'b0;
			o0_dev <= 1'b0;
			o1_dev <= 1'b0;
		end
	end

	// Device replies, registered later by the multiplexer
	assign mi = mi_dev;
	assign i0 = i0_dev;
	assign i1 = i1_dev;

endmodule

/* source/spi_link_if.sv */
`timescale 1ns/100ps

interface spi_link_if;

	// Synchronized microcontroller levels
	logic cs_addr;
	logic cs;
	logic ck;
	logic mo;
	logic o0;
	logic o1;

	// One-cycle rise strobes
	logic ck_rise;
	logic cs_rise;
	logic cs_addr_rise;

	// Synchronizer side
	modport src (output cs_addr, cs, ck, mo, o0, o1, ck_rise, cs_rise, cs_addr_rise);

	// Address loader, channels and output registers
	modport dst (input cs_addr, cs, ck, mo, o0, o1, ck_rise, cs_rise, cs_addr_rise);

endinterface

/* source/spi_sync.sv */
`timescale 1ns/100ps

module spi_sync (
	input  logic    clk,
	input  logic    rst,
	input  logic    cs_addr_u,
	input  logic    cs_u,
	input  logic    ck_u,
	input  logic    mo_u,
	input  logic    o0_u,
	input  logic    o1_u,
	spi_link_if.src link
);

	// Bit order in all vectors: cs_addr, cs, ck, mo, o0, o1
	logic [5:0]                              pins;
	logic [bridge_pkg::SYNC_STAGES-1:0][5:0] stage;
	logic [5:0]                              level;
	// Previous cs_addr, cs, ck for edge detection
	logic [2:0]                              prev;

	assign pins = {cs_addr_u, cs_u, ck_u, mo_u, o0_u, o1_u};

	// ************************************************************************
	// Synchronizer chain
	// ************************************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			// Chip selects idle high, rest low
			stage <= {bridge_pkg::SYNC_STAGES{6'b110000}};
			prev  <= 3'b110;
		end else begin
			stage <= {stage[bridge_pkg::SYNC_STAGES-2:0], pins};
			prev  <= level[5:3];
		end
	end

	// Last stage is the clk-domain level
	assign level = stage[bridge_pkg::SYNC_STAGES-1];

	assign link.cs_addr = level[5];
	assign link.cs      = level[4];
	assign link.ck      = level[3];
	assign link.mo      = level[2];
	assign link.o0      = level[1];
	assign link.o1      = level[0];

	// Rise strobes, high in the first cycle of the new level
	assign link.cs_addr_rise = level[5] & ~prev[2];
	assign link.cs_rise      = level[4] & ~prev[1];
	assign link.ck_rise      = level[3] & ~prev[0];

endmodule
